//--- source/linebuf_pkg.sv
package linebuf_pkg;

  // pixel and size input widths.
  localparam int DWIDTH = 16;
  localparam int LWIDTH = 6;

  // largest supported filter and image edges.
  localparam int MAXFIL = 5;
  localparam int MAXIMG = 32;

  // widest padding a MAXFIL filter can use.
  localparam int MAXPAD = (MAXFIL - 1) / 2;

  // one line memory holds a full image row plus one spare word.
  localparam int BUFSIZE = MAXIMG + 1;

  // one extra line so a row can be written while MAXFIL older rows are read
  localparam int BUFLINE = MAXFIL + 1;

  // column address width.
  localparam int SIZEWIDTH = $clog2(BUFSIZE);

  // line index width. selects add one bit, 0 means no line.
  localparam int LINEWIDTH = $clog2(BUFLINE);

  // signed image sample.
  typedef logic signed [DWIDTH-1:0] pixel_t;

endpackage

//--- source/linebuf_ctrl.sv
`timescale 1ns/1ps

module linebuf_ctrl (
  input  logic                              clk,
  input  logic                              xrst,
  input  logic [linebuf_pkg::LWIDTH-1:0]    img_size,
  input  logic [linebuf_pkg::LWIDTH-1:0]    fil_size,
  input  logic [linebuf_pkg::LWIDTH-1:0]    pad_size,
  input  logic                              req,
  output logic                              ack,
  output logic                              ready,
  output logic                              wcol,
  output logic                              we,
  output logic                              start,
  output logic                              valid,
  output logic                              stop,
  output logic [linebuf_pkg::LINEWIDTH:0]   wsel,
  output logic [linebuf_pkg::LINEWIDTH:0]   rsel,
  output logic [linebuf_pkg::MAXFIL-1:0]    rrow,
  output logic [linebuf_pkg::SIZEWIDTH-1:0] addr
);
  import linebuf_pkg::*;

  typedef enum logic [1:0] {
    S_WAIT,
    S_CHARGE,
    S_ACTIVE
  } state_t;

  state_t               state;
  logic                 running;
  logic [SIZEWIDTH-1:0] img_w;
  logic [SIZEWIDTH-1:0] fil_w;
  logic [SIZEWIDTH-1:0] pad_w;
  logic [SIZEWIDTH-1:0] col_last;
  logic                 col_end;
  logic                 charge_end;
  logic                 active_end;

  logic [SIZEWIDTH-1:0] col_count;
  logic [SIZEWIDTH-1:0] row_count;
  logic [LINEWIDTH-1:0] mem_count;

  logic [LINEWIDTH:0]   rsel_base;
  logic [LINEWIDTH:0]   rsel_next;
  logic [MAXFIL-1:0]    rrow_next;
  logic [LINEWIDTH:0]   rsel_pipe [2];
  logic [MAXFIL-1:0]    rrow_pipe [2];

  logic [2:0]           ack_pipe;
  logic [2:0]           start_pipe;
  logic [2:0]           valid_pipe;
  logic [2:0]           stop_pipe;

  assign img_w = SIZEWIDTH'(img_size);
  assign fil_w = SIZEWIDTH'(fil_size);
  assign pad_w = SIZEWIDTH'(pad_size);

  assign running  = state != S_WAIT;
  assign col_last = img_w + pad_w + pad_w - SIZEWIDTH'(1); // padded row width minus one.
  assign col_end  = col_count == col_last;

  // lines above the first window row are filled before output starts.
  assign charge_end = state == S_CHARGE && col_end
                   && row_count == fil_w - pad_w - SIZEWIDTH'(1);
  assign active_end = state == S_ACTIVE && col_end
                   && row_count == img_w + pad_w;

  always_ff @(posedge clk) begin
    if (!xrst) begin
      state <= S_WAIT;
    end else begin
      case (state)
        S_WAIT:   if (req && ack) state <= S_CHARGE;
        S_CHARGE: if (charge_end) state <= S_ACTIVE;
        S_ACTIVE: if (active_end) state <= S_WAIT;
        default:  state <= S_WAIT;
      endcase
    end
  end

  // ack rises three cycles after the return to idle.
  always_ff @(posedge clk) begin
    if (!xrst)
      ack_pipe <= '0;
    else
      ack_pipe <= {ack_pipe[1:0], state == S_WAIT};
  end

  assign ack = state == S_WAIT && ack_pipe[2];

  always_ff @(posedge clk) begin
    if (!xrst) begin
      col_count <= '0;
      row_count <= '0;
      mem_count <= '0;
    end else if (!running) begin
      col_count <= '0;
      row_count <= '0;
      mem_count <= '0;
    end else if (col_end) begin
      col_count <= '0;
      row_count <= row_count + SIZEWIDTH'(1);
      if (mem_count == LINEWIDTH'(BUFLINE - 1))
        mem_count <= '0;                                    // line ring wraps.
      else
        mem_count <= mem_count + LINEWIDTH'(1);
    end else begin
      col_count <= col_count + SIZEWIDTH'(1);
    end
  end

  // real image pixel at this counter position.
  assign ready = running
              && row_count < img_w
              && col_count >= pad_w
              && col_count < img_w + pad_w;

  // filter row 0 reads the line written fil_size rows ago.
  always_comb begin
    rsel_base = {1'b0, mem_count} + (LINEWIDTH+1)'(BUFLINE) - fil_size[LINEWIDTH:0];
    if (rsel_base >= (LINEWIDTH+1)'(BUFLINE))
      rsel_base = rsel_base - (LINEWIDTH+1)'(BUFLINE);
    rsel_next = rsel_base + (LINEWIDTH+1)'(1);
  end

  // row j is live when it lies below the top padding and inside the filter.
  for (genvar j = 0; j < MAXFIL; j++) begin : g_rrow
    assign rrow_next[j] = SIZEWIDTH'(j) < fil_w
                       && row_count + SIZEWIDTH'(j) >= fil_w;
  end

  always_ff @(posedge clk) begin
    if (!xrst) begin
      wsel         <= '0;
      rsel_pipe[0] <= '0;
      rsel_pipe[1] <= '0;
      rrow_pipe[0] <= '0;
      rrow_pipe[1] <= '0;
    end else begin
      wsel         <= running ? {1'b0, mem_count} + (LINEWIDTH+1)'(1) : '0;
      rsel_pipe[0] <= running ? rsel_next : '0;
      rsel_pipe[1] <= rsel_pipe[0];                         // aligned with bank read data.
      rrow_pipe[0] <= running ? rrow_next : '0;
      rrow_pipe[1] <= rrow_pipe[0];
    end
  end

  assign rsel = rsel_pipe[1];
  assign rrow = rrow_pipe[1];

  always_ff @(posedge clk) begin
    if (!xrst) begin
      we   <= 1'b0;
      addr <= '0;
      wcol <= 1'b0;
    end else begin
      we   <= running && row_count < img_w + pad_w;         // bottom pad rows store zero.
      addr <= running ? col_count : '0;
      wcol <= ready;                                        // pixel arrives one cycle later.
    end
  end

  always_ff @(posedge clk) begin
    if (!xrst) begin
      start_pipe <= '0;
      valid_pipe <= '0;
      stop_pipe  <= '0;
    end else begin
      start_pipe <= {start_pipe[1:0], state == S_ACTIVE && row_count == fil_w - pad_w
                                      && col_count == fil_w - SIZEWIDTH'(1)};
      valid_pipe <= {valid_pipe[1:0], state == S_ACTIVE
                                      && col_count >= fil_w - SIZEWIDTH'(1)};
      stop_pipe  <= {stop_pipe[1:0], active_end};
    end
  end

  assign start = start_pipe[2];
  assign valid = valid_pipe[2];
  assign stop  = stop_pipe[2];

  a_req_sizes: assert property (@(posedge clk) disable iff (!xrst)
    req |-> fil_size[0] && fil_size <= LWIDTH'(MAXFIL) && pad_size < fil_size
            && pad_size <= LWIDTH'(MAXPAD)
            && int'(img_size) + 2 * int'(pad_size) <= BUFSIZE);

  // the last window hands the bank straight back to a new frame.
  a_stop_ack: assert property (@(posedge clk) disable iff (!xrst)
    stop |=> ack);

endmodule

//--- source/linebuf_bank.sv
`timescale 1ns/1ps

module linebuf_bank (
  input  logic                              clk,
  input  logic                              we,
  input  logic                              wcol,
  input  logic [linebuf_pkg::LINEWIDTH:0]   wsel,
  input  logic [linebuf_pkg::SIZEWIDTH-1:0] addr,
  input  linebuf_pkg::pixel_t               pixel,
  output linebuf_pkg::pixel_t               rdata [linebuf_pkg::BUFLINE]
);
  import linebuf_pkg::*;

  pixel_t             mem [BUFLINE][BUFSIZE];  // line k+1 lives at index k.
  pixel_t             wdata;
  logic [BUFLINE-1:0] line_we;

  // padding columns and rows are written as zero.
  assign wdata = wcol ? pixel : '0;

  // one-hot write decode, select 0 writes nothing.
  always_comb begin
    for (int k = 0; k < BUFLINE; k++)
      line_we[k] = we && wsel == (LINEWIDTH+1)'(k + 1);
  end

  // every line is read at the same column each cycle.
  always_ff @(posedge clk) begin
    for (int k = 0; k < BUFLINE; k++) begin
      if (line_we[k])
        mem[k][addr] <= wdata;
      rdata[k] <= mem[k][addr];                 // one cycle read latency.
    end
  end

  a_wsel_range: assert property (@(posedge clk)
    we |-> wsel inside {[1:BUFLINE]});

endmodule

//--- source/window_shift.sv
`timescale 1ns/1ps

module window_shift (
  input  logic                            clk,
  input  logic                            xrst,
  input  linebuf_pkg::pixel_t             rdata [linebuf_pkg::BUFLINE],
  input  logic [linebuf_pkg::LINEWIDTH:0] rsel,
  input  logic [linebuf_pkg::MAXFIL-1:0]  rrow,
  output linebuf_pkg::pixel_t             win [linebuf_pkg::MAXFIL*linebuf_pkg::MAXFIL]
);
  import linebuf_pkg::*;

  pixel_t col_in [MAXFIL];              // new column, filter row order.
  pixel_t shift_src [MAXFIL][MAXFIL];   // right neighbour of each entry.
  pixel_t win_r [MAXFIL][MAXFIL];
  int     edge_col;                     // column where new data enters.

  // line index of filter row, counted from rsel around the ring
  function automatic int line_of(input logic [LINEWIDTH:0] sel, input int row);
    return (int'(sel) + BUFLINE - 1 + row) % BUFLINE;
  endfunction

  // rotate into row order and blank rows outside the image.
  always_comb begin
    for (int i = 0; i < MAXFIL; i++)
      col_in[i] = rrow[i] ? rdata[line_of(rsel, i)] : '0;
  end

  // top live row of rrow is fil_size - 1 during a frame.
  // the window's right edge sits at that column.
  always_comb begin
    edge_col = MAXFIL - 1;
    for (int j = 0; j < MAXFIL; j++)
      if (rrow[j])
        edge_col = j;
  end

  for (genvar i = 0; i < MAXFIL; i++) begin : g_row
    for (genvar j = 0; j < MAXFIL; j++) begin : g_col
      if (j < MAXFIL - 1) begin : g_inner
        assign shift_src[i][j] = win_r[i][j+1];
      end else begin : g_last
        assign shift_src[i][j] = col_in[i];
      end
      assign win[i*MAXFIL + j] = win_r[i][j];   // row-major output.
    end
  end

  // columns move left by one and the new column enters at the edge.
  always_ff @(posedge clk) begin
    if (!xrst) begin
      for (int i = 0; i < MAXFIL; i++)
        for (int j = 0; j < MAXFIL; j++)
          win_r[i][j] <= '0;
    end else begin
      for (int i = 0; i < MAXFIL; i++) begin
        for (int j = 0; j < MAXFIL; j++) begin
          if (j == edge_col)
            win_r[i][j] <= col_in[i];
          else
            win_r[i][j] <= shift_src[i][j];
        end
      end
    end
  end

endmodule

//--- source/linebuf_top.sv
`timescale 1ns/1ps

module linebuf_top (
  input  logic                            clk,
  input  logic                            xrst,
  input  logic [linebuf_pkg::LWIDTH-1:0]  img_size,
  input  logic [linebuf_pkg::LWIDTH-1:0]  fil_size,
  input  logic [linebuf_pkg::LWIDTH-1:0]  pad_size,
  input  logic                            req,
  input  linebuf_pkg::pixel_t             pixel,
  output logic                            ack,
  output logic                            ready,
  output logic                            start,
  output logic                            valid,
  output logic                            stop,
  output linebuf_pkg::pixel_t             win [linebuf_pkg::MAXFIL*linebuf_pkg::MAXFIL]
);
  import linebuf_pkg::*;

  logic                 we;
  logic                 wcol;
  logic [LINEWIDTH:0]   wsel;
  logic [LINEWIDTH:0]   rsel;
  logic [MAXFIL-1:0]    rrow;
  logic [SIZEWIDTH-1:0] addr;
  pixel_t               rdata [BUFLINE];   // one word per line, same column.

  linebuf_ctrl u_ctrl (
    .clk      (clk),
    .xrst     (xrst),
    .img_size (img_size),
    .fil_size (fil_size),
    .pad_size (pad_size),
    .req      (req),
    .ack      (ack),
    .ready    (ready),
    .wcol     (wcol),
    .we       (we),
    .start    (start),
    .valid    (valid),
    .stop     (stop),
    .wsel     (wsel),
    .rsel     (rsel),
    .rrow     (rrow),
    .addr     (addr)
  );

  linebuf_bank u_bank (
    .clk   (clk),
    .we    (we),
    .wcol  (wcol),
    .wsel  (wsel),
    .addr  (addr),
    .pixel (pixel),
    .rdata (rdata)
  );

  window_shift u_shift (
    .clk   (clk),
    .xrst  (xrst),
    .rdata (rdata),
    .rsel  (rsel),
    .rrow  (rrow),
    .win   (win)
  );

endmodule

//--- testbench/tb_linebuf.sv
`timescale 1ns/1ps

module tb_linebuf;
  import linebuf_pkg::*;

  // padded width times a generous row count per frame.
  function automatic int frame_budget(input int img_e, input int fil_e, input int pad_e);
    return (img_e + 2 * pad_e) * (img_e + fil_e + pad_e + 2) + 50;
  endfunction

  // all frames of the run plus reset and the idle check.
  localparam int TIMEOUT_LIMIT = frame_budget(8, 3, 1) + frame_budget(12, 5, 2)
                               + frame_budget(10, 3, 0) + frame_budget(8, 3, 1)
                               + frame_budget(7, 5, 1) + 50;

  logic              clk;
  logic              xrst;
  logic [LWIDTH-1:0] img_size;
  logic [LWIDTH-1:0] fil_size;
  logic [LWIDTH-1:0] pad_size;
  logic              req;
  pixel_t            pixel;
  logic              ack;
  logic              ready;
  logic              start;
  logic              valid;
  logic              stop;
  pixel_t            win [MAXFIL*MAXFIL];

  pixel_t img [MAXIMG][MAXIMG];  // frame being streamed.
  int     cur_img;
  int     cur_fil;
  int     cur_pad;
  int     win_idx = 0;           // window index inside the frame.
  int     valid_total = 0;
  int     start_total = 0;
  int     stop_total = 0;
  int     cycle_count = 0;

  linebuf_top UUT (
    .clk      (clk),
    .xrst     (xrst),
    .img_size (img_size),
    .fil_size (fil_size),
    .pad_size (pad_size),
    .req      (req),
    .pixel    (pixel),
    .ack      (ack),
    .ready    (ready),
    .start    (start),
    .valid    (valid),
    .stop     (stop),
    .win      (win)
  );

  initial begin
    clk = 1'b0;
    forever #10 clk = ~clk;
  end

  always @(posedge clk) begin : watchdog
    cycle_count++;
    if (cycle_count > TIMEOUT_LIMIT) begin
      $display("timeout: the frames did not finish within %0d cycles", TIMEOUT_LIMIT);
      $display(">>> FAIL");
      $fatal(1, "run stopped by the cycle limit");
    end
  end

  task automatic check_pixel(input pixel_t expected, input pixel_t actual, input string what);
    if (expected !== actual) begin
      $display("** Error at %0t: %s expected %0d got %0d", $time, what, expected, actual);
      $display(">>> FAIL");
      $fatal(1, "pixel mismatch");
    end
  endtask

  task automatic check_count(input int expected, input int actual, input string what);
    if (expected != actual) begin
      $display("** Error at %0t: %s expected %0d got %0d", $time, what, expected, actual);
      $display(">>> FAIL");
      $fatal(1, "count mismatch");
    end
  endtask

  // zero in the padding ring outside the image.
  function automatic pixel_t model_pixel(input int r, input int c, input int i, input int j);
    int y;
    int x;
    y = r + i - cur_pad;
    x = c + j - cur_pad;
    if (y >= 0 && y < cur_img && x >= 0 && x < cur_img)
      return img[y][x];
    return '0;
  endfunction

  function automatic int windows_per_frame();
    int ow;
    ow = cur_img + 2 * cur_pad - cur_fil + 1;
    return ow * ow;
  endfunction

  task automatic compare_window(input int idx);
    int ow;
    int r;
    int c;
    ow = cur_img + 2 * cur_pad - cur_fil + 1;
    r = idx / ow;
    c = idx % ow;
    for (int i = 0; i < cur_fil; i++)
      for (int j = 0; j < cur_fil; j++)
        check_pixel(model_pixel(r, c, i, j), win[i*MAXFIL + j],
                    $sformatf("window (%0d,%0d) entry (%0d,%0d)", r, c, i, j));
  endtask

  // each valid window against the reference model.
  always @(negedge clk) begin : monitor
    if (xrst && (start || stop))
      check_count(1, int'(valid), "valid with start or stop");
    if (xrst && valid) begin
      compare_window(win_idx);
      if (start) begin
        check_count(0, win_idx, "window index at start");
        start_total++;
      end
      valid_total++;
      if (stop) begin
        stop_total++;
        win_idx = 0;
      end else begin
        win_idx++;
      end
    end
  end

  // next raster pixel in the cycle after ready.
  initial begin : pixel_source
    int src_idx;
    src_idx = 0;
    pixel = '0;
    forever begin
      @(posedge clk);
      if (ack) begin
        src_idx = 0;
      end else if (ready) begin
        pixel <= img[src_idx / cur_img][src_idx % cur_img];
        src_idx++;
      end
    end
  end

  task automatic fill_image(input int img_e);
    for (int y = 0; y < img_e; y++)
      for (int x = 0; x < img_e; x++)
        img[y][x] = pixel_t'($urandom);
  endtask

  task automatic wait_ack();
    while (!ack)
      @(posedge clk);
  endtask

  // one frame from req to stop with an optional req while busy.
  task automatic run_frame(input int img_e, input int fil_e, input int pad_e,
                           input bit busy_req);
    int v0;
    int s0;
    int p0;
    wait_ack();
    fill_image(img_e);
    cur_img = img_e;
    cur_fil = fil_e;
    cur_pad = pad_e;
    img_size <= LWIDTH'(img_e);
    fil_size <= LWIDTH'(fil_e);
    pad_size <= LWIDTH'(pad_e);
    @(posedge clk);
    v0 = valid_total;
    s0 = start_total;
    p0 = stop_total;
    req <= 1'b1;
    @(posedge clk);
    req <= 1'b0;
    if (busy_req) begin
      while (valid_total - v0 < 10)
        @(posedge clk);
      check_count(0, int'(ack), "ack while busy");
      req <= 1'b1;
      @(posedge clk);
      req <= 1'b0;
    end
    while (stop_total == p0)
      @(posedge clk);
    check_count(windows_per_frame(), valid_total - v0, "windows in frame");
    check_count(1, start_total - s0, "start pulses");
  endtask

  task automatic idle_after_reset();
    @(negedge clk);
    check_count(0, int'(valid), "valid after reset");
    check_count(0, int'(start), "start after reset");
    check_count(0, int'(stop), "stop after reset");
    check_count(0, int'(ready), "ready after reset");
    check_count(0, int'(ack), "ack right after reset");
    wait_ack();
  endtask

  task automatic pad_one_frame();
    run_frame(8, 3, 1, 1'b0);
  endtask

  task automatic pad_two_frame();
    run_frame(12, 5, 2, 1'b0);
  endtask

  task automatic unpadded_frame();
    run_frame(10, 3, 0, 1'b0);
  endtask

  // busy req ignored and a second frame straight after.
  task automatic busy_req_ignored();
    run_frame(8, 3, 1, 1'b1);
    @(negedge clk);
    check_count(1, int'(ack), "ack in the cycle after stop");
    @(posedge clk);
    run_frame(7, 5, 1, 1'b0);
  endtask

  initial begin
    void'($urandom(34359));
    xrst = 1'b0;
    req = 1'b0;
    img_size = '0;
    fil_size = '0;
    pad_size = '0;
    cur_img = 1;
    cur_fil = 1;
    cur_pad = 0;
    repeat (5) @(posedge clk);
    xrst <= 1'b1;
    idle_after_reset();
    pad_one_frame();
    pad_two_frame();
    unpadded_frame();
    busy_req_ignored();
    repeat (5) @(posedge clk);
    $display(">>> PASS");
    $finish;
  end

endmodule

//--- verilog.f
source/linebuf_pkg.sv
source/linebuf_ctrl.sv
source/linebuf_bank.sv
source/window_shift.sv
source/linebuf_top.sv
testbench/tb_linebuf.sv

//--- run.sh
#!/bin/sh
# Build and run the line-buffer testbench with Verilator.
# The exit status is the simulator's own: nonzero on any failure.

cd "$(dirname "$0")" || exit 1

verilator --binary --timing --assert -j 0 \
  --top-module tb_linebuf \
  -f verilog.f \
  -o sim_linebuf
status=$?
if [ $status -ne 0 ]; then
  echo "verilator build failed with status $status"
  exit $status
fi

./obj_dir/sim_linebuf
status=$?
if [ $status -ne 0 ]; then
  echo "simulation failed with status $status"
  exit $status
fi

exit 0
